// ==== src/cu_consts.svh ====
//--------------------------------------------------------------------------
// Control unit constants
// Word and field widths, instruction field positions, opcode and funct
// codes of the supported MIPS-like instruction set
//--------------------------------------------------------------------------
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Widths
`define CU_DATA_W      32
`define CU_REG_ADDR_W  5
`define CU_OPC_W       6
`define CU_FN_W        6
`define CU_IMM_W       16

// Field positions, LSB of each field
`define CU_OPC_LSB     26
`define CU_RS_LSB      21
`define CU_RT_LSB      16
`define CU_RD_LSB      11
`define CU_SHAMT_LSB   6
`define CU_FN_LSB      0

// Opcodes
`define CU_OPC_RTYPE   6'h00
`define CU_OPC_ADDI    6'h08
`define CU_OPC_MULI    6'h1d
`define CU_OPC_ANDI    6'h0c
`define CU_OPC_ORI     6'h0d
`define CU_OPC_LUI     6'h0f
`define CU_OPC_SLTI    6'h0a
`define CU_OPC_BEQ     6'h04
`define CU_OPC_BNE     6'h05
`define CU_OPC_LW      6'h23
`define CU_OPC_SW      6'h2b
`define CU_OPC_J       6'h02
`define CU_OPC_JAL     6'h03

// R-type funct codes
`define CU_FN_ADD      6'h20
`define CU_FN_SUB      6'h22
`define CU_FN_MUL      6'h2c
`define CU_FN_AND      6'h24
`define CU_FN_OR       6'h25
`define CU_FN_NOR      6'h27
`define CU_FN_SLT      6'h2a
`define CU_FN_SLL      6'h01
`define CU_FN_SRL      6'h02
`define CU_FN_JR       6'h08

// jal writes its return address here
`define CU_LINK_REG    31

`endif

// ==== src/cu_pkg.sv ====
//--------------------------------------------------------------------------
// Control unit package
// Width types, stage and select enums, decoded instruction record,
// datapath control word and APB request
//--------------------------------------------------------------------------
`default_nettype none

`include "cu_consts.svh"

package cu_pkg;

  // Plain widths
  typedef logic [`CU_DATA_W-1:0]     word_t;
  typedef logic [`CU_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CU_OPC_W-1:0]      opcode_t;
  typedef logic [`CU_FN_W-1:0]       funct_t;

  // Multi-cycle stages, one instruction at a time
  typedef enum logic [2:0] {
    STG_FETCH, STG_DECODE, STG_EXECUTE, STG_MEMORY, STG_WRITEBACK
  } proc_stage_t;

  // Instruction classes, grouped by how the datapath treats them
  typedef enum logic [3:0] {
    CLS_ALU_REG, CLS_ALU_SHIFT, CLS_ALU_IMM_S, CLS_ALU_IMM_Z, CLS_LUI,
    CLS_BEQ, CLS_BNE, CLS_LOAD, CLS_STORE, CLS_JR, CLS_JUMP, CLS_JAL,
    CLS_ILLEGAL
  } instr_class_t;

  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_MUL, ALU_SHL, ALU_SHR,
    ALU_AND, ALU_OR, ALU_NOR, ALU_SLT
  } alu_op_t;

  // Next PC source
  typedef enum logic [2:0] {PC_HOLD, PC_INC, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_t;

  // Register write address source
  typedef enum logic [1:0] {WSEL_RD, WSEL_RT, WSEL_LINK} wsel_t;

  // Register write data source
  typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_LUI_IMM, WD_PC_NEXT} wdata_sel_t;

  // ALU second operand source
  typedef enum logic [1:0] {SRC2_REG, SRC2_SIMM, SRC2_ZIMM, SRC2_SHAMT} src2_sel_t;

  // Held for the whole life of one instruction
  typedef struct packed {
    instr_class_t iclass;
    alu_op_t      alu_op;
    src2_sel_t    src2_sel;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
  } decoded_instr_t;

  // Per-stage control word to the datapath
  typedef struct packed {
    pc_sel_t    pc_sel;
    logic       rf_read;
    logic       rf_write;
    wsel_t      wsel;
    wdata_sel_t wdata_sel;
    alu_op_t    alu_op;
    src2_sel_t  src2_sel;
    logic       ir_load;
  } ctrl_word_t;

  // APB requester strobes, address and data come from the datapath
  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
  } apb_req_t;

endpackage

`default_nettype wire

// ==== src/cu_sequencer.sv ====
//--------------------------------------------------------------------------
// Stage sequencer
// Five-stage FSM with the APB requester phases for instruction fetch
// and the lw/sw data access, stretched by pready
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cu_sequencer (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   pready,
  input  cu_pkg::decoded_instr_t dec,
  output cu_pkg::proc_stage_t    stage,
  output cu_pkg::apb_req_t       apb,
  output logic                   ir_load
);
  import cu_pkg::*;

  proc_stage_t stage_nxt;
  apb_req_t    apb_nxt;
  logic        xfer_done;
  logic        data_xfer;

  // Access phase with pready high ends the transfer
  assign xfer_done = apb.psel & apb.penable & pready;
  assign data_xfer = (dec.iclass == CLS_LOAD) || (dec.iclass == CLS_STORE);

  // Instruction register captures prdata on the fetch completion edge
  assign ir_load = (stage == STG_FETCH) && xfer_done;

  always_comb
  begin
    stage_nxt = stage;
    apb_nxt   = apb;
    // Setup phase is always a single cycle
    if (apb.psel && !apb.penable)
    begin
      apb_nxt.penable = 1'b1;
    end
    case (stage)
      STG_FETCH:
      begin
        if (xfer_done)
        begin
          stage_nxt = STG_DECODE;
          apb_nxt   = '0;
        end
      end
      STG_DECODE: stage_nxt = STG_EXECUTE;
      STG_EXECUTE:
      begin
        stage_nxt = STG_MEMORY;
        // Data access starts together with the memory stage
        if (data_xfer)
        begin
          apb_nxt.psel   = 1'b1;
          apb_nxt.pwrite = (dec.iclass == CLS_STORE);
        end
      end
      STG_MEMORY:
      begin
        // Single cycle when idle, else wait for completion
        if (!apb.psel || xfer_done)
        begin
          stage_nxt = STG_WRITEBACK;
          apb_nxt   = '0;
        end
      end
      STG_WRITEBACK:
      begin
        stage_nxt    = STG_FETCH;
        apb_nxt      = '0;
        apb_nxt.psel = 1'b1;
      end
      default:
      begin
        // Unused encodings fall back into write-back
        stage_nxt = STG_WRITEBACK;
        apb_nxt   = '0;
      end
    endcase
  end

  // Reset parks in write-back so the first edge out of reset opens a fetch
  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      stage <= STG_WRITEBACK;
      apb   <= '0;
    end
    else
    begin
      stage <= stage_nxt;
      apb   <= apb_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== src/cu_instr_reg.sv ====
//--------------------------------------------------------------------------
// Instruction register
// Splits the fetched word and keeps it as a decoded instruction record
// for the five stages of its life
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "cu_consts.svh"

module cu_instr_reg (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   ir_load,
  input  cu_pkg::word_t          prdata,
  output cu_pkg::decoded_instr_t dec
);
  import cu_pkg::*;

  opcode_t        opcode;
  funct_t         funct;
  decoded_instr_t dec_nxt;

  // Record with class, ALU op and operand select, fields cleared
  function automatic decoded_instr_t kind(
    input instr_class_t c,
    input alu_op_t      op,
    input src2_sel_t    s2
  );
    decoded_instr_t d;
    d          = '0;
    d.iclass   = c;
    d.alu_op   = op;
    d.src2_sel = s2;
    return d;
  endfunction

  assign opcode = prdata[`CU_OPC_LSB +: `CU_OPC_W];
  assign funct  = prdata[`CU_FN_LSB +: `CU_FN_W];

  always_comb
  begin
    case (opcode)
      `CU_OPC_RTYPE:
      begin
        case (funct)
          `CU_FN_ADD: dec_nxt = kind(CLS_ALU_REG, ALU_ADD, SRC2_REG);
          `CU_FN_SUB: dec_nxt = kind(CLS_ALU_REG, ALU_SUB, SRC2_REG);
          `CU_FN_MUL: dec_nxt = kind(CLS_ALU_REG, ALU_MUL, SRC2_REG);
          `CU_FN_AND: dec_nxt = kind(CLS_ALU_REG, ALU_AND, SRC2_REG);
          `CU_FN_OR:  dec_nxt = kind(CLS_ALU_REG, ALU_OR, SRC2_REG);
          `CU_FN_NOR: dec_nxt = kind(CLS_ALU_REG, ALU_NOR, SRC2_REG);
          `CU_FN_SLT: dec_nxt = kind(CLS_ALU_REG, ALU_SLT, SRC2_REG);
          // Shifts take the amount from the shamt field
          `CU_FN_SLL: dec_nxt = kind(CLS_ALU_SHIFT, ALU_SHL, SRC2_SHAMT);
          `CU_FN_SRL: dec_nxt = kind(CLS_ALU_SHIFT, ALU_SHR, SRC2_SHAMT);
          `CU_FN_JR:  dec_nxt = kind(CLS_JR, ALU_NOP, SRC2_REG);
          default:    dec_nxt = kind(CLS_ILLEGAL, ALU_NOP, SRC2_REG);
        endcase
      end
      `CU_OPC_ADDI: dec_nxt = kind(CLS_ALU_IMM_S, ALU_ADD, SRC2_SIMM);
      `CU_OPC_MULI: dec_nxt = kind(CLS_ALU_IMM_S, ALU_MUL, SRC2_SIMM);
      `CU_OPC_SLTI: dec_nxt = kind(CLS_ALU_IMM_S, ALU_SLT, SRC2_SIMM);
      // Logical immediates are zero extended
      `CU_OPC_ANDI: dec_nxt = kind(CLS_ALU_IMM_Z, ALU_AND, SRC2_ZIMM);
      `CU_OPC_ORI:  dec_nxt = kind(CLS_ALU_IMM_Z, ALU_OR, SRC2_ZIMM);
      `CU_OPC_LUI:  dec_nxt = kind(CLS_LUI, ALU_NOP, SRC2_REG);
      // Branches compare by subtraction, zero flag decides
      `CU_OPC_BEQ:  dec_nxt = kind(CLS_BEQ, ALU_SUB, SRC2_REG);
      `CU_OPC_BNE:  dec_nxt = kind(CLS_BNE, ALU_SUB, SRC2_REG);
      // Address is base plus signed offset
      `CU_OPC_LW:   dec_nxt = kind(CLS_LOAD, ALU_ADD, SRC2_SIMM);
      `CU_OPC_SW:   dec_nxt = kind(CLS_STORE, ALU_ADD, SRC2_SIMM);
      `CU_OPC_J:    dec_nxt = kind(CLS_JUMP, ALU_NOP, SRC2_REG);
      `CU_OPC_JAL:  dec_nxt = kind(CLS_JAL, ALU_NOP, SRC2_REG);
      default:      dec_nxt = kind(CLS_ILLEGAL, ALU_NOP, SRC2_REG);
    endcase
    dec_nxt.rs = prdata[`CU_RS_LSB +: `CU_REG_ADDR_W];
    dec_nxt.rt = prdata[`CU_RT_LSB +: `CU_REG_ADDR_W];
    dec_nxt.rd = prdata[`CU_RD_LSB +: `CU_REG_ADDR_W];
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      dec <= kind(CLS_ILLEGAL, ALU_NOP, SRC2_REG);
    end
    else if (ir_load)
    begin
      dec <= dec_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== src/cu_ctrl_gen.sv ====
//--------------------------------------------------------------------------
// Control word generator
// Combinational control word per stage from the decoded instruction
// and the ALU zero flag
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cu_ctrl_gen (
  input  cu_pkg::proc_stage_t    stage,
  input  cu_pkg::decoded_instr_t dec,
  input  logic                   zero,
  output cu_pkg::ctrl_word_t     ctrl
);
  import cu_pkg::*;

  logic       branch_taken;
  logic       writes_rf;
  wsel_t      wb_wsel;
  wdata_sel_t wb_wdata;
  pc_sel_t    wb_pc;

  // beq on equal, bne on not equal
  assign branch_taken = ((dec.iclass == CLS_BEQ) && zero) ||
                        ((dec.iclass == CLS_BNE) && !zero);

  // Classes with a register result
  assign writes_rf = dec.iclass inside {CLS_ALU_REG, CLS_ALU_SHIFT, CLS_ALU_IMM_S,
                                        CLS_ALU_IMM_Z, CLS_LUI, CLS_LOAD, CLS_JAL};

  //------------------------------------------------------------------------
  // Write-back selects
  //------------------------------------------------------------------------
  always_comb
  begin
    // Immediate forms write rt, jal writes the link register
    case (dec.iclass)
      CLS_ALU_IMM_S, CLS_ALU_IMM_Z, CLS_LUI, CLS_LOAD: wb_wsel = WSEL_RT;
      CLS_JAL: wb_wsel = WSEL_LINK;
      default: wb_wsel = WSEL_RD;
    endcase

    case (dec.iclass)
      CLS_LOAD: wb_wdata = WD_MEM;
      CLS_LUI:  wb_wdata = WD_LUI_IMM;
      CLS_JAL:  wb_wdata = WD_PC_NEXT;
      default:  wb_wdata = WD_ALU;
    endcase

    // Illegal codes just step over
    case (dec.iclass)
      CLS_BEQ, CLS_BNE:  wb_pc = branch_taken ? PC_BRANCH : PC_INC;
      CLS_JUMP, CLS_JAL: wb_pc = PC_JUMP;
      CLS_JR:            wb_pc = PC_REG;
      default:           wb_pc = PC_INC;
    endcase
  end

  //------------------------------------------------------------------------
  // Per-stage control word
  //------------------------------------------------------------------------
  always_comb
  begin
    // Idle word, PC held and no register write
    ctrl.pc_sel    = PC_HOLD;
    ctrl.rf_read   = 1'b0;
    ctrl.rf_write  = 1'b0;
    ctrl.wsel      = WSEL_RD;
    ctrl.wdata_sel = WD_ALU;
    ctrl.alu_op    = ALU_NOP;
    ctrl.src2_sel  = SRC2_REG;
    ctrl.ir_load   = 1'b0;
    case (stage)
      STG_FETCH: ctrl.ir_load = 1'b1;
      // Read rs and rt
      STG_DECODE: ctrl.rf_read = 1'b1;
      STG_EXECUTE:
      begin
        // NOP and REG already come from decode for non-ALU classes
        ctrl.alu_op   = dec.alu_op;
        ctrl.src2_sel = dec.src2_sel;
      end
      STG_MEMORY:
      begin
        // sw needs the store data, jr the target register
        ctrl.rf_read = (dec.iclass == CLS_STORE) || (dec.iclass == CLS_JR);
      end
      STG_WRITEBACK:
      begin
        ctrl.rf_write  = writes_rf;
        ctrl.wsel      = wb_wsel;
        ctrl.wdata_sel = wb_wdata;
        ctrl.pc_sel    = wb_pc;
      end
      default: ctrl.ir_load = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cu_top.sv ====
//--------------------------------------------------------------------------
// Control unit top level
// Stage sequencer, instruction register and control word generator
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cu_top (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                zero,
  input  logic                pready,
  input  cu_pkg::word_t       prdata,
  output cu_pkg::apb_req_t    apb,
  output cu_pkg::proc_stage_t stage,
  output cu_pkg::ctrl_word_t  ctrl
);
  import cu_pkg::*;

  // Fetch completion strobe
  logic           ir_load;
  // Current instruction, stable from decode to write-back
  decoded_instr_t dec;

  cu_sequencer seq_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .pready  (pready),
    .dec     (dec),
    .stage   (stage),
    .apb     (apb),
    .ir_load (ir_load)
  );

  cu_instr_reg ireg_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .ir_load (ir_load),
    .prdata  (prdata),
    .dec     (dec)
  );

  cu_ctrl_gen cgen_i (
    .stage (stage),
    .dec   (dec),
    .zero  (zero),
    .ctrl  (ctrl)
  );

endmodule

`default_nettype wire

// ==== tests/cu_chk.sv ====
//--------------------------------------------------------------------------
// Control unit protocol checks
// Reset values and APB requester handshake, bound into the top level
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cu_chk (
  input logic                CLK,
  input logic                rst_n,
  input logic                pready,
  input cu_pkg::apb_req_t    apb,
  input cu_pkg::proc_stage_t stage,
  input cu_pkg::ctrl_word_t  ctrl,
  input logic                ir_load
);
  import cu_pkg::*;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Registers show their reset values one cycle after a reset edge
  reset_idle: assert property (@(posedge CLK)
    !rst_n |=> !apb.psel && !apb.penable && !ctrl.rf_write && !ctrl.ir_load && !ir_load)
  else
  begin
    $error("bus or control outputs active during reset");
    fail_cnt++;
  end

  // First cycle out of reset opens the fetch setup phase
  reset_exit: assert property (@(posedge CLK)
    $rose(rst_n) |=> stage == STG_FETCH && apb.psel && !apb.penable && !ctrl.rf_write
                     && !ir_load)
  else
  begin
    $error("first cycle after reset is not a fetch setup");
    fail_cnt++;
  end

  // Setup phase lasts exactly one cycle
  setup_to_access: assert property (@(posedge CLK) disable iff (!rst_n)
    apb.psel && !apb.penable |=> apb.psel && apb.penable && $stable(apb.pwrite))
  else
  begin
    $error("setup phase not followed by access phase");
    fail_cnt++;
  end

  // Wait states freeze the bus, the stage and the control word
  wait_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    apb.psel && apb.penable && !pready |=>
      apb.psel && apb.penable && $stable(apb.pwrite) && $stable(stage) && $stable(ctrl))
  else
  begin
    $error("state changed during a wait cycle");
    fail_cnt++;
  end

  // psel drops after completion
  release_bus: assert property (@(posedge CLK) disable iff (!rst_n)
    apb.penable && pready |=> !apb.psel)
  else
  begin
    $error("psel still high after completed access");
    fail_cnt++;
  end

  enable_needs_sel: assert property (@(posedge CLK) disable iff (!rst_n)
    apb.penable |-> apb.psel)
  else
  begin
    $error("penable high without psel");
    fail_cnt++;
  end

endmodule

bind cu_top cu_chk chk_i (
  .CLK     (CLK),
  .rst_n   (rst_n),
  .pready  (pready),
  .apb     (apb),
  .stage   (stage),
  .ctrl    (ctrl),
  .ir_load (ir_load)
);

`default_nettype wire

// ==== tests/cu_tb.sv ====
//--------------------------------------------------------------------------
// Control unit testbench
// APB memory model feeding an instruction list, per-stage control word
// checks and data access counts per instruction
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "cu_consts.svh"

module cu_tb;
  import cu_pkg::*;

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_WAIT     = 3;
  localparam int NUM_INSTR    = 26;
  // Slowest instruction is 7 cycles plus full waits on fetch and data, doubled
  localparam int WATCHDOG_CYC = 2 * (NUM_INSTR * (7 + 2 * MAX_WAIT) + RESET_CYCLES);

  // Data access kind of an instruction
  localparam logic [1:0] M_NO = 2'd0;
  localparam logic [1:0] M_RD = 2'd1;
  localparam logic [1:0] M_WR = 2'd2;

  // One instruction and what it should make the unit do
  typedef struct packed {
    word_t      instr;
    logic       zero;
    alu_op_t    alu_op;
    src2_sel_t  src2_sel;
    logic       rf_write;
    wsel_t      wsel;
    wdata_sel_t wdata_sel;
    pc_sel_t    pc_sel;
    logic [1:0] mem;
  } case_t;

  logic        CLK = 1'b0;
  logic        rst_n;
  logic        zero;
  logic        pready;
  word_t       prdata;
  apb_req_t    apb;
  proc_stage_t stage;
  ctrl_word_t  ctrl;

  case_t       prog[$];
  int          cur;
  int          wait_left;
  int          rd_cnt;
  int          wr_cnt;
  int          done_cnt;
  int          errors;
  // Stage seen at the previous falling edge
  proc_stage_t prev_stage;

  cu_top dut_i (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .zero   (zero),
    .pready (pready),
    .prdata (prdata),
    .apb    (apb),
    .stage  (stage),
    .ctrl   (ctrl)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  task automatic flag_error(input string msg);
    errors++;
    $display("** Error [%0t] %s", $time, msg);
  endtask

  // R-type word with random register fields
  function automatic word_t r_word(input funct_t fn);
    word_t w;
    w = $urandom;
    w[`CU_OPC_LSB +: `CU_OPC_W] = `CU_OPC_RTYPE;
    w[`CU_FN_LSB +: `CU_FN_W]   = fn;
    return w;
  endfunction

  // I-type or J-type word, random below the opcode
  function automatic word_t op_word(input opcode_t opc);
    word_t w;
    w = $urandom;
    w[`CU_OPC_LSB +: `CU_OPC_W] = opc;
    return w;
  endfunction

  task automatic add_case(input word_t w, input alu_op_t op, input src2_sel_t s2,
                          input logic wr, input wsel_t ws, input wdata_sel_t wd,
                          input pc_sel_t pc, input logic [1:0] mem, input logic z = 1'b0);
    case_t tc;
    tc.instr     = w;
    tc.zero      = z;
    tc.alu_op    = op;
    tc.src2_sel  = s2;
    tc.rf_write  = wr;
    tc.wsel      = ws;
    tc.wdata_sel = wd;
    tc.pc_sel    = pc;
    tc.mem       = mem;
    prog.push_back(tc);
  endtask

  //------------------------------------------------------------------------
  // Instruction list with expected execute and write-back behavior
  //------------------------------------------------------------------------
  task automatic build_program();
    add_case(r_word(`CU_FN_ADD), ALU_ADD, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_SUB), ALU_SUB, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_MUL), ALU_MUL, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_AND), ALU_AND, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_OR), ALU_OR, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_NOR), ALU_NOR, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_SLT), ALU_SLT, SRC2_REG, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_SLL), ALU_SHL, SRC2_SHAMT, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_SRL), ALU_SHR, SRC2_SHAMT, 1'b1, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(`CU_FN_JR), ALU_NOP, SRC2_REG, 1'b0, WSEL_RD, WD_ALU, PC_REG, M_NO);
    add_case(op_word(`CU_OPC_ADDI), ALU_ADD, SRC2_SIMM, 1'b1, WSEL_RT, WD_ALU, PC_INC, M_NO);
    add_case(op_word(`CU_OPC_MULI), ALU_MUL, SRC2_SIMM, 1'b1, WSEL_RT, WD_ALU, PC_INC, M_NO);
    add_case(op_word(`CU_OPC_ANDI), ALU_AND, SRC2_ZIMM, 1'b1, WSEL_RT, WD_ALU, PC_INC, M_NO);
    add_case(op_word(`CU_OPC_ORI), ALU_OR, SRC2_ZIMM, 1'b1, WSEL_RT, WD_ALU, PC_INC, M_NO);
    add_case(op_word(`CU_OPC_LUI), ALU_NOP, SRC2_REG, 1'b1, WSEL_RT, WD_LUI_IMM, PC_INC, M_NO);
    add_case(op_word(`CU_OPC_SLTI), ALU_SLT, SRC2_SIMM, 1'b1, WSEL_RT, WD_ALU, PC_INC, M_NO);
    // Both zero values for each branch
    add_case(op_word(`CU_OPC_BEQ), ALU_SUB, SRC2_REG, 1'b0, WSEL_RD, WD_ALU,
             PC_BRANCH, M_NO, 1'b1);
    add_case(op_word(`CU_OPC_BEQ), ALU_SUB, SRC2_REG, 1'b0, WSEL_RD, WD_ALU,
             PC_INC, M_NO, 1'b0);
    add_case(op_word(`CU_OPC_BNE), ALU_SUB, SRC2_REG, 1'b0, WSEL_RD, WD_ALU,
             PC_INC, M_NO, 1'b1);
    add_case(op_word(`CU_OPC_BNE), ALU_SUB, SRC2_REG, 1'b0, WSEL_RD, WD_ALU,
             PC_BRANCH, M_NO, 1'b0);
    add_case(op_word(`CU_OPC_LW), ALU_ADD, SRC2_SIMM, 1'b1, WSEL_RT, WD_MEM, PC_INC, M_RD);
    add_case(op_word(`CU_OPC_SW), ALU_ADD, SRC2_SIMM, 1'b0, WSEL_RD, WD_ALU, PC_INC, M_WR);
    add_case(op_word(`CU_OPC_J), ALU_NOP, SRC2_REG, 1'b0, WSEL_RD, WD_ALU, PC_JUMP, M_NO);
    add_case(op_word(`CU_OPC_JAL), ALU_NOP, SRC2_REG, 1'b1, WSEL_LINK, WD_PC_NEXT, PC_JUMP, M_NO);
    // Undefined opcode and undefined funct
    add_case(op_word(6'h3f), ALU_NOP, SRC2_REG, 1'b0, WSEL_RD, WD_ALU, PC_INC, M_NO);
    add_case(r_word(6'h3e), ALU_NOP, SRC2_REG, 1'b0, WSEL_RD, WD_ALU, PC_INC, M_NO);
  endtask

  // Control word the stage rules call for
  function automatic ctrl_word_t expected_ctrl(input proc_stage_t stg, input case_t tc);
    ctrl_word_t c;
    c.pc_sel    = PC_HOLD;
    c.rf_read   = 1'b0;
    c.rf_write  = 1'b0;
    c.wsel      = WSEL_RD;
    c.wdata_sel = WD_ALU;
    c.alu_op    = ALU_NOP;
    c.src2_sel  = SRC2_REG;
    c.ir_load   = 1'b0;
    case (stg)
      STG_FETCH: c.ir_load = 1'b1;
      STG_DECODE: c.rf_read = 1'b1;
      STG_EXECUTE:
      begin
        c.alu_op   = tc.alu_op;
        c.src2_sel = tc.src2_sel;
      end
      // sw reads store data, jr its target register
      STG_MEMORY: c.rf_read = (tc.mem == M_WR) || (tc.pc_sel == PC_REG);
      STG_WRITEBACK:
      begin
        c.rf_write  = tc.rf_write;
        c.wsel      = tc.wsel;
        c.wdata_sel = tc.wdata_sel;
        c.pc_sel    = tc.pc_sel;
      end
      default: c.ir_load = 1'b0;
    endcase
    return c;
  endfunction

  // Fixed stage order of one instruction
  function automatic proc_stage_t stage_after(input proc_stage_t stg);
    case (stg)
      STG_FETCH:   return STG_DECODE;
      STG_DECODE:  return STG_EXECUTE;
      STG_EXECUTE: return STG_MEMORY;
      STG_MEMORY:  return STG_WRITEBACK;
      default:     return STG_FETCH;
    endcase
  endfunction

  // Only fetch and memory may last longer, and only during a bus access
  task automatic check_order();
    if (stage == prev_stage)
    begin
      assert ((stage == STG_FETCH || stage == STG_MEMORY) && apb.psel)
      else flag_error($sformatf("%s held for more than one cycle without a bus access",
                                stage.name()));
    end
    else
    begin
      assert (stage == stage_after(prev_stage))
      else flag_error($sformatf("stage %s followed %s",
                                stage.name(), prev_stage.name()));
    end
  endtask

  task automatic check_stage(input case_t tc);
    ctrl_word_t exp;
    exp = expected_ctrl(stage, tc);
    assert (ctrl == exp)
    else flag_error($sformatf("%s ctrl for %h is %h, expected %h",
                              stage.name(), tc.instr, ctrl, exp));
    if (stage == STG_WRITEBACK)
    begin
      // Exactly the data accesses the instruction calls for
      assert (rd_cnt == int'(tc.mem == M_RD) && wr_cnt == int'(tc.mem == M_WR))
      else flag_error($sformatf("instr %h made %0d reads and %0d writes",
                                tc.instr, rd_cnt, wr_cnt));
      done_cnt++;
    end
  endtask

  //------------------------------------------------------------------------
  // APB memory model, 0 to MAX_WAIT wait cycles per access
  //------------------------------------------------------------------------
  task automatic serve_apb();
    pready = 1'b0;
    if (apb.psel && !apb.penable)
    begin
      wait_left = $urandom % (MAX_WAIT + 1);
      if (stage == STG_FETCH)
      begin
        cur++;
        rd_cnt = 0;
        wr_cnt = 0;
        prdata = (cur < NUM_INSTR) ? prog[cur].instr : '0;
      end
      else
      begin
        if (apb.pwrite)
        begin
          wr_cnt++;
        end
        else
        begin
          rd_cnt++;
        end
        prdata = $urandom;
      end
    end
    else if (apb.psel && apb.penable)
    begin
      pready = (wait_left == 0);
      if (wait_left > 0)
      begin
        wait_left--;
      end
    end
  endtask

  // Check settled outputs first, then drive the next inputs
  always @(negedge CLK)
  begin
    if (rst_n && cur >= 0 && cur < NUM_INSTR)
    begin
      check_order();
      check_stage(prog[cur]);
    end
    prev_stage = stage;
    serve_apb();
    zero = (cur >= 0 && cur < NUM_INSTR) ? prog[cur].zero : 1'b0;
  end

  initial
  begin
    void'($urandom(32'hf3e5));
    rst_n      = 1'b0;
    zero       = 1'b0;
    pready     = 1'b0;
    prdata     = '0;
    cur        = -1;
    wait_left  = 0;
    rd_cnt     = 0;
    wr_cnt     = 0;
    done_cnt   = 0;
    errors     = 0;
    prev_stage = STG_WRITEBACK;
    build_program();
    repeat (RESET_CYCLES) @(negedge CLK);
    rst_n = 1'b1;
    wait (done_cnt == NUM_INSTR);
    // Let the last bound properties complete
    repeat (2) @(negedge CLK);
    $display("Instructions %0d, errors %0d, assertion failures %0d",
             done_cnt, errors, dut_i.chk_i.fail_cnt);
    if (errors == 0 && dut_i.chk_i.fail_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge CLK);
    $display("Timeout after %0d cycles with %0d of %0d instructions done",
             WATCHDOG_CYC, done_cnt, NUM_INSTR);
    $display("Instructions %0d, errors %0d, assertion failures %0d",
             done_cnt, errors, dut_i.chk_i.fail_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/cu_pkg.sv
src/cu_sequencer.sv
src/cu_instr_reg.sv
src/cu_ctrl_gen.sv
src/cu_top.sv
tests/cu_chk.sv
tests/cu_tb.sv

// ==== Makefile ====
# Verilator simulation of the control unit
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cu_tb
FILELIST  = build.f
SIMFLAGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
